/* logic/htif_config.svh */
`ifndef HTIF_CONFIG_SVH
`define HTIF_CONFIG_SVH

// HTIF register pair seen on the core's memory port
`define HTIF_TOHOST_ADDR   64'h0000_0000_8000_1000
`define HTIF_FROMHOST_ADDR 64'h0000_0000_8000_1040

// UART-lite device on the system bus
`define UART_BASE          64'h0000_0000_1000_0000
`define UART_FIFO_OFS      64'd0
`define UART_STAT_OFS      64'd8

`define UART_RX_VALID_BIT  0
`define UART_TX_FULL_BIT   3
`define UART_TX_STRB       8'b0001_0000 // byte lane 4

`endif

/* logic/bus_pkg.sv */
package bus_pkg;

    typedef logic [63:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;
    typedef logic [7:0]  bus_strb_t;
    typedef logic [7:0]  bus_len_t;  // beats minus one

endpackage

/* logic/htif_pkg.sv */
package htif_pkg;

    typedef logic [7:0] htif_dev_t;     // tohost 63:56
    typedef logic [7:0] htif_cmd_t;     // tohost 55:48
    typedef logic [7:0] console_byte_t;

    typedef enum logic [3:0] {
        cs_idle,
        cs_stat_addr,  // AR to status register
        cs_stat_wait,
        cs_tx_addr,
        cs_tx_wait,    // W beat of the tx byte
        cs_resp_wait,
        cs_rx_addr,
        cs_rx_wait,
        cs_done
    } console_state_t;

endpackage

/* logic/htif_slave.sv */
`timescale 1ns/10ps
`include "htif_config.svh"

module htif_slave (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    core_arvalid,
    input  logic                    core_awvalid,
    input  logic                    core_wvalid,
    input  logic                    core_rready,
    input  logic                    core_bready,
    input  bus_pkg::bus_addr_t      core_araddr,
    input  bus_pkg::bus_addr_t      core_awaddr,
    input  bus_pkg::bus_len_t       core_arlen,
    input  bus_pkg::bus_len_t       core_awlen,
    input  bus_pkg::bus_data_t      core_wdata,
    input  logic                    console_done,
    input  logic                    rx_strobe,
    input  htif_pkg::console_byte_t rx_char,
    output logic                    htif_active,
    output logic                    s_arready,
    output logic                    s_awready,
    output logic                    s_wready,
    output logic                    s_rvalid,
    output logic                    s_bvalid,
    output bus_pkg::bus_data_t      s_rdata,
    output logic                    console_start,
    output logic                    console_rx_mode,
    output htif_pkg::console_byte_t tx_char
);
    import bus_pkg::*;
    import htif_pkg::*;

    logic      on_htif;
    logic      job;
    logic      aw_done;
    logic      w_done;
    logic      rx_pend;
    logic      ar_hit;
    logic      aw_hit;
    logic      ar_hs;
    logic      aw_hs;
    logic      w_hs;
    logic      r_hs;
    logic      b_hs;
    logic      wr_fire;
    logic      to_console;
    bus_addr_t waddr;
    bus_addr_t waddr_now;
    bus_data_t wdata;
    bus_data_t wdata_now;
    bus_data_t tohost;
    bus_data_t fromhost;
    htif_dev_t to_dev;
    htif_cmd_t to_cmd;

    // single-beat access to one of the two registers, only when idle
    assign ar_hit = ~on_htif & core_arvalid & (core_arlen == '0) &
                    (core_araddr == `HTIF_TOHOST_ADDR | core_araddr == `HTIF_FROMHOST_ADDR);
    assign aw_hit = ~on_htif & core_awvalid & (core_awlen == '0) &
                    (core_awaddr == `HTIF_TOHOST_ADDR | core_awaddr == `HTIF_FROMHOST_ADDR);
    assign htif_active = on_htif | ar_hit | aw_hit;

    assign s_arready = htif_active & ~job & ~s_rvalid;
    assign s_awready = htif_active & ~job & ~aw_done;
    assign s_wready  = htif_active & ~job & ~w_done;

    assign ar_hs = core_arvalid & s_arready;
    assign aw_hs = core_awvalid & s_awready;
    assign w_hs  = core_wvalid & s_wready;
    assign r_hs  = s_rvalid & core_rready;
    assign b_hs  = s_bvalid & core_bready;

    // both halves of the write present, this cycle or earlier
    assign wr_fire   = (aw_done | aw_hs) & (w_done | w_hs) & ~s_bvalid;
    assign waddr_now = aw_done ? waddr : core_awaddr;
    assign wdata_now = w_done ? wdata : core_wdata;

    assign to_dev     = tohost[63:56];
    assign to_cmd     = tohost[55:48];
    assign to_console = (to_dev == 8'd1) & (to_cmd == 8'd1); // console putchar
    assign tx_char    = tohost[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            on_htif         <= 1'b0;
            job             <= 1'b0;
            aw_done         <= 1'b0;
            w_done          <= 1'b0;
            rx_pend         <= 1'b0;
            s_rvalid        <= 1'b0;
            s_bvalid        <= 1'b0;
            console_start   <= 1'b0;
            console_rx_mode <= 1'b0;
            tohost          <= '0;
            fromhost        <= '0;
        end else begin
            console_start <= 1'b0;
            if (ar_hit | aw_hit) on_htif <= 1'b1;
            if (ar_hs) begin
                s_rvalid <= 1'b1;
                rx_pend  <= (core_araddr == `HTIF_FROMHOST_ADDR) & (fromhost == '0);
            end
            if (aw_hs) aw_done <= 1'b1;
            if (w_hs) w_done <= 1'b1;
            if (wr_fire) begin
                s_bvalid <= 1'b1;
                if (waddr_now == `HTIF_TOHOST_ADDR) tohost <= wdata_now;
                if (waddr_now == `HTIF_FROMHOST_ADDR) fromhost <= wdata_now;
            end
            if (r_hs) begin
                s_rvalid <= 1'b0;
                if (rx_pend) begin // empty poll, go ask the UART
                    job             <= 1'b1;
                    console_start   <= 1'b1;
                    console_rx_mode <= 1'b1;
                end else begin
                    on_htif <= 1'b0;
                end
            end
            if (b_hs) begin
                s_bvalid <= 1'b0;
                aw_done  <= 1'b0;
                w_done   <= 1'b0;
                if (waddr == `HTIF_TOHOST_ADDR & to_console) begin
                    job             <= 1'b1;
                    console_start   <= 1'b1;
                    console_rx_mode <= 1'b0;
                end else begin
                    if (waddr == `HTIF_TOHOST_ADDR) tohost <= '0; // command consumed
                    on_htif <= 1'b0;
                end
            end
            if (rx_strobe) fromhost <= {8'd1, 8'd0, 40'd0, rx_char};
            if (console_done) begin
                job     <= 1'b0;
                on_htif <= 1'b0;
                if (~console_rx_mode) tohost <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) s_rdata <= (core_araddr == `HTIF_TOHOST_ADDR) ? tohost : fromhost;
        if (aw_hs) waddr <= core_awaddr;
        if (w_hs) wdata <= core_wdata;
    end

endmodule

/* logic/console_master.sv */
`timescale 1ns/10ps
`include "htif_config.svh"

module console_master (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    console_start,
    input  logic                    console_rx_mode,
    input  htif_pkg::console_byte_t tx_char,
    input  logic                    mem_arready,
    input  logic                    mem_rvalid,
    input  logic                    mem_awready,
    input  logic                    mem_wready,
    input  logic                    mem_bvalid,
    input  bus_pkg::bus_data_t      mem_rdata,
    output logic                    c_arvalid,
    output logic                    c_rready,
    output logic                    c_awvalid,
    output logic                    c_wvalid,
    output logic                    c_wlast,
    output logic                    c_bready,
    output bus_pkg::bus_addr_t      c_araddr,
    output bus_pkg::bus_addr_t      c_awaddr,
    output bus_pkg::bus_data_t      c_wdata,
    output bus_pkg::bus_strb_t      c_wstrb,
    output logic                    console_done,
    output logic                    rx_strobe,
    output htif_pkg::console_byte_t rx_char
);
    import bus_pkg::*;
    import htif_pkg::*;

    console_state_t state;
    logic           rx_valid;
    logic           tx_full;

    assign rx_valid = mem_rdata[`UART_RX_VALID_BIT];
    assign tx_full  = mem_rdata[`UART_TX_FULL_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cs_idle;
        end else begin
            case (state)
                cs_idle: if (console_start) state <= cs_stat_addr;
                cs_stat_addr: if (mem_arready) state <= cs_stat_wait;
                cs_stat_wait: begin
                    if (mem_rvalid) begin
                        if (console_rx_mode) begin
                            state <= rx_valid ? cs_rx_addr : cs_done;
                        end else begin
                            state <= tx_full ? cs_stat_addr : cs_tx_addr; // poll again
                        end
                    end
                end
                cs_tx_addr: if (mem_awready) state <= cs_tx_wait;
                cs_tx_wait: if (mem_wready) state <= cs_resp_wait;
                cs_resp_wait: if (mem_bvalid) state <= cs_done;
                cs_rx_addr: if (mem_arready) state <= cs_rx_wait;
                cs_rx_wait: if (mem_rvalid) state <= cs_done;
                cs_done: state <= cs_idle;
                default: state <= cs_idle;
            endcase
        end
    end

    // read side
    assign c_arvalid = (state == cs_stat_addr) | (state == cs_rx_addr);
    assign c_araddr  = (state == cs_rx_addr) ? `UART_BASE + `UART_FIFO_OFS
                                             : `UART_BASE + `UART_STAT_OFS;
    assign c_rready  = (state == cs_stat_wait) | (state == cs_rx_wait);

    // write side, one beat
    assign c_awvalid = state == cs_tx_addr;
    assign c_awaddr  = `UART_BASE + `UART_FIFO_OFS;
    assign c_wvalid  = state == cs_tx_wait;
    assign c_wdata   = {24'd0, tx_char, 32'd0}; // byte on lane 4
    assign c_wstrb   = `UART_TX_STRB;
    assign c_wlast   = 1'b1;
    assign c_bready  = state == cs_resp_wait;

    assign rx_strobe    = (state == cs_rx_wait) & mem_rvalid;
    assign rx_char      = mem_rdata[7:0];
    assign console_done = state == cs_done;

endmodule

/* logic/bus_steer.sv */
`timescale 1ns/10ps

module bus_steer (
    input  logic               htif_active,
    input  logic               core_arvalid,
    input  logic               core_awvalid,
    input  logic               core_wvalid,
    input  logic               core_wlast,
    input  logic               core_rready,
    input  logic               core_bready,
    input  bus_pkg::bus_addr_t core_araddr,
    input  bus_pkg::bus_addr_t core_awaddr,
    input  bus_pkg::bus_len_t  core_arlen,
    input  bus_pkg::bus_len_t  core_awlen,
    input  bus_pkg::bus_data_t core_wdata,
    input  bus_pkg::bus_strb_t core_wstrb,
    input  logic               s_arready,
    input  logic               s_awready,
    input  logic               s_wready,
    input  logic               s_rvalid,
    input  logic               s_bvalid,
    input  bus_pkg::bus_data_t s_rdata,
    input  logic               c_arvalid,
    input  logic               c_rready,
    input  logic               c_awvalid,
    input  logic               c_wvalid,
    input  logic               c_wlast,
    input  logic               c_bready,
    input  bus_pkg::bus_addr_t c_araddr,
    input  bus_pkg::bus_addr_t c_awaddr,
    input  bus_pkg::bus_data_t c_wdata,
    input  bus_pkg::bus_strb_t c_wstrb,
    input  logic               mem_arready,
    input  logic               mem_awready,
    input  logic               mem_wready,
    input  logic               mem_rvalid,
    input  logic               mem_rlast,
    input  logic               mem_bvalid,
    input  bus_pkg::bus_data_t mem_rdata,
    output logic               core_arready,
    output logic               core_awready,
    output logic               core_wready,
    output logic               core_rvalid,
    output logic               core_rlast,
    output logic               core_bvalid,
    output bus_pkg::bus_data_t core_rdata,
    output logic               mem_arvalid,
    output logic               mem_awvalid,
    output logic               mem_wvalid,
    output logic               mem_wlast,
    output logic               mem_rready,
    output logic               mem_bready,
    output bus_pkg::bus_addr_t mem_araddr,
    output bus_pkg::bus_addr_t mem_awaddr,
    output bus_pkg::bus_len_t  mem_arlen,
    output bus_pkg::bus_len_t  mem_awlen,
    output bus_pkg::bus_data_t mem_wdata,
    output bus_pkg::bus_strb_t mem_wstrb
);

    // core side answers come from the HTIF slave while active
    assign core_arready = htif_active ? s_arready : mem_arready;
    assign core_awready = htif_active ? s_awready : mem_awready;
    assign core_wready  = htif_active ? s_wready  : mem_wready;
    assign core_rvalid  = htif_active ? s_rvalid  : mem_rvalid;
    assign core_rdata   = htif_active ? s_rdata   : mem_rdata;
    assign core_rlast   = htif_active | mem_rlast; // HTIF reads are one beat
    assign core_bvalid  = htif_active ? s_bvalid  : mem_bvalid;

    // bus side requests come from the console master while active
    assign mem_arvalid = htif_active ? c_arvalid : core_arvalid;
    assign mem_araddr  = htif_active ? c_araddr  : core_araddr;
    assign mem_arlen   = htif_active ? '0        : core_arlen;
    assign mem_rready  = htif_active ? c_rready  : core_rready;
    assign mem_awvalid = htif_active ? c_awvalid : core_awvalid;
    assign mem_awaddr  = htif_active ? c_awaddr  : core_awaddr;
    assign mem_awlen   = htif_active ? '0        : core_awlen;
    assign mem_wvalid  = htif_active ? c_wvalid  : core_wvalid;
    assign mem_wdata   = htif_active ? c_wdata   : core_wdata;
    assign mem_wstrb   = htif_active ? c_wstrb   : core_wstrb;
    assign mem_wlast   = htif_active ? c_wlast   : core_wlast;
    assign mem_bready  = htif_active ? c_bready  : core_bready;

endmodule

/* logic/htif_uart_bridge.sv */
`timescale 1ns/10ps

module htif_uart_bridge (
    input  logic               clk,
    input  logic               rst,
    input  logic               core_arvalid,
    output logic               core_arready,
    input  bus_pkg::bus_addr_t core_araddr,
    input  bus_pkg::bus_len_t  core_arlen,
    output logic               core_rvalid,
    input  logic               core_rready,
    output bus_pkg::bus_data_t core_rdata,
    output logic               core_rlast,
    input  logic               core_awvalid,
    output logic               core_awready,
    input  bus_pkg::bus_addr_t core_awaddr,
    input  bus_pkg::bus_len_t  core_awlen,
    input  logic               core_wvalid,
    output logic               core_wready,
    input  bus_pkg::bus_data_t core_wdata,
    input  bus_pkg::bus_strb_t core_wstrb,
    input  logic               core_wlast,
    output logic               core_bvalid,
    input  logic               core_bready,
    output logic               mem_arvalid,
    input  logic               mem_arready,
    output bus_pkg::bus_addr_t mem_araddr,
    output bus_pkg::bus_len_t  mem_arlen,
    input  logic               mem_rvalid,
    output logic               mem_rready,
    input  bus_pkg::bus_data_t mem_rdata,
    input  logic               mem_rlast,
    output logic               mem_awvalid,
    input  logic               mem_awready,
    output bus_pkg::bus_addr_t mem_awaddr,
    output bus_pkg::bus_len_t  mem_awlen,
    output logic               mem_wvalid,
    input  logic               mem_wready,
    output bus_pkg::bus_data_t mem_wdata,
    output bus_pkg::bus_strb_t mem_wstrb,
    output logic               mem_wlast,
    input  logic               mem_bvalid,
    output logic               mem_bready
);
    import bus_pkg::*;
    import htif_pkg::*;

    logic          htif_active;
    logic          s_arready, s_awready, s_wready, s_rvalid, s_bvalid;
    bus_data_t     s_rdata;
    logic          console_start, console_rx_mode, console_done;
    logic          rx_strobe;
    console_byte_t tx_char, rx_char;
    logic          c_arvalid, c_rready, c_awvalid, c_wvalid, c_wlast, c_bready;
    bus_addr_t     c_araddr, c_awaddr;
    bus_data_t     c_wdata;
    bus_strb_t     c_wstrb;

    htif_slave u_slave (
        .clk(clk), .rst(rst),
        .core_arvalid(core_arvalid), .core_awvalid(core_awvalid),
        .core_wvalid(core_wvalid), .core_rready(core_rready), .core_bready(core_bready),
        .core_araddr(core_araddr), .core_awaddr(core_awaddr),
        .core_arlen(core_arlen), .core_awlen(core_awlen), .core_wdata(core_wdata),
        .console_done(console_done), .rx_strobe(rx_strobe), .rx_char(rx_char),
        .htif_active(htif_active),
        .s_arready(s_arready), .s_awready(s_awready), .s_wready(s_wready),
        .s_rvalid(s_rvalid), .s_bvalid(s_bvalid), .s_rdata(s_rdata),
        .console_start(console_start), .console_rx_mode(console_rx_mode),
        .tx_char(tx_char)
    );

    console_master u_console (
        .clk(clk), .rst(rst),
        .console_start(console_start), .console_rx_mode(console_rx_mode),
        .tx_char(tx_char),
        .mem_arready(mem_arready), .mem_rvalid(mem_rvalid), .mem_awready(mem_awready),
        .mem_wready(mem_wready), .mem_bvalid(mem_bvalid), .mem_rdata(mem_rdata),
        .c_arvalid(c_arvalid), .c_rready(c_rready), .c_awvalid(c_awvalid),
        .c_wvalid(c_wvalid), .c_wlast(c_wlast), .c_bready(c_bready),
        .c_araddr(c_araddr), .c_awaddr(c_awaddr), .c_wdata(c_wdata), .c_wstrb(c_wstrb),
        .console_done(console_done), .rx_strobe(rx_strobe), .rx_char(rx_char)
    );

    bus_steer u_steer (
        .htif_active(htif_active),
        .core_arvalid(core_arvalid), .core_awvalid(core_awvalid),
        .core_wvalid(core_wvalid), .core_wlast(core_wlast),
        .core_rready(core_rready), .core_bready(core_bready),
        .core_araddr(core_araddr), .core_awaddr(core_awaddr),
        .core_arlen(core_arlen), .core_awlen(core_awlen),
        .core_wdata(core_wdata), .core_wstrb(core_wstrb),
        .s_arready(s_arready), .s_awready(s_awready), .s_wready(s_wready),
        .s_rvalid(s_rvalid), .s_bvalid(s_bvalid), .s_rdata(s_rdata),
        .c_arvalid(c_arvalid), .c_rready(c_rready), .c_awvalid(c_awvalid),
        .c_wvalid(c_wvalid), .c_wlast(c_wlast), .c_bready(c_bready),
        .c_araddr(c_araddr), .c_awaddr(c_awaddr), .c_wdata(c_wdata), .c_wstrb(c_wstrb),
        .mem_arready(mem_arready), .mem_awready(mem_awready), .mem_wready(mem_wready),
        .mem_rvalid(mem_rvalid), .mem_rlast(mem_rlast), .mem_bvalid(mem_bvalid),
        .mem_rdata(mem_rdata),
        .core_arready(core_arready), .core_awready(core_awready),
        .core_wready(core_wready), .core_rvalid(core_rvalid), .core_rlast(core_rlast),
        .core_bvalid(core_bvalid), .core_rdata(core_rdata),
        .mem_arvalid(mem_arvalid), .mem_awvalid(mem_awvalid), .mem_wvalid(mem_wvalid),
        .mem_wlast(mem_wlast), .mem_rready(mem_rready), .mem_bready(mem_bready),
        .mem_araddr(mem_araddr), .mem_awaddr(mem_awaddr),
        .mem_arlen(mem_arlen), .mem_awlen(mem_awlen),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb)
    );

endmodule

/* test/bridge_tb.sv */
`timescale 1ns/10ps
`include "htif_config.svh"

module bridge_tb;
    import bus_pkg::*;

    localparam int NROWS = 14;
    localparam int LIMIT = 64 * NROWS + 16; // cycles for the whole run
    localparam bus_addr_t ORD_ADDR = 64'h0000_0000_8000_0000;
    localparam bus_addr_t STAT_ADDR = `UART_BASE + `UART_STAT_OFS;
    localparam bus_addr_t FIFO_ADDR = `UART_BASE + `UART_FIFO_OFS;
    localparam bus_addr_t UART_END = `UART_BASE + 64'h100;

    logic clk = 1'b0;
    logic rst;
    logic core_arvalid, core_arready, core_rvalid, core_rready, core_rlast;
    logic core_awvalid, core_awready, core_wvalid, core_wready, core_wlast;
    logic core_bvalid, core_bready;
    bus_addr_t core_araddr, core_awaddr;
    bus_len_t  core_arlen, core_awlen;
    bus_data_t core_rdata, core_wdata;
    bus_strb_t core_wstrb;
    logic mem_arvalid, mem_arready, mem_rvalid, mem_rready, mem_rlast;
    logic mem_awvalid, mem_awready, mem_wvalid, mem_wready, mem_wlast;
    logic mem_bvalid, mem_bready;
    bus_addr_t mem_araddr, mem_awaddr;
    bus_len_t  mem_arlen, mem_awlen;
    bus_data_t mem_rdata, mem_wdata;
    bus_strb_t mem_wstrb;

    // stimulus table
    logic       t_write   [NROWS];
    bus_addr_t  t_addr    [NROWS];
    bus_data_t  t_wdata   [NROWS];
    int         t_full    [NROWS]; // status polls that report tx full
    logic       t_rx      [NROWS];
    logic [7:0] t_rx_byte [NROWS];
    bus_data_t  t_rdata   [NROWS];
    int         t_stat    [NROWS];
    int         t_fifo    [NROWS];
    int         t_uwr     [NROWS];
    logic [7:0] t_tx_byte [NROWS];

    int nrow = 0;
    int cur = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int stat_base = 0, fifo_base = 0, uwr_base = 0;

    // memory and UART model state
    int stat_reads = 0, fifo_reads = 0, uart_writes = 0;
    bus_addr_t last_waddr, aw_addr;
    bus_data_t last_wdata, w_data, rd;
    bus_strb_t last_wstrb;
    logic got_aw, got_w;
    bus_data_t mem_store [bus_addr_t];
    logic [7:0] cx, cy, rb;
    bus_data_t ord_data, fv;

    htif_uart_bridge DUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: no response from the DUT after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        mem_arready = 1'b0;
        mem_awready = 1'b0;
        mem_wready = 1'b0;
        mem_rvalid = 1'b0;
        mem_rlast = 1'b0;
        mem_bvalid = 1'b0;
        mem_rdata = '0;
        got_aw = 1'b0;
        got_w = 1'b0;
        forever begin
            @(posedge clk);
            mem_arready <= ~rst;
            mem_awready <= ~rst;
            mem_wready <= ~rst;
            if (mem_rvalid && mem_rready) begin
                mem_rvalid <= 1'b0;
                mem_rlast <= 1'b0;
            end
            if (mem_arvalid && mem_arready) begin
                check("mem_arlen", 64'(mem_arlen), 64'h0);
                if (mem_araddr == STAT_ADDR) begin
                    rd = '0;
                    rd[`UART_TX_FULL_BIT] = (stat_reads - stat_base) < t_full[cur];
                    rd[`UART_RX_VALID_BIT] = t_rx[cur] && (fifo_reads == fifo_base);
                    stat_reads++;
                end else if (mem_araddr == FIFO_ADDR) begin
                    rd = {56'd0, t_rx_byte[cur]};
                    fifo_reads++;
                end else begin
                    rd = mem_store.exists(mem_araddr) ? mem_store[mem_araddr] : '0;
                end
                mem_rvalid <= 1'b1;
                mem_rlast <= 1'b1;
                mem_rdata <= rd;
            end
            if (mem_awvalid && mem_awready) begin
                check("mem_awlen", 64'(mem_awlen), 64'h0);
                got_aw = 1'b1;
                aw_addr = mem_awaddr;
            end
            if (mem_wvalid && mem_wready) begin
                check("mem_wlast", 64'(mem_wlast), 64'h1);
                got_w = 1'b1;
                w_data = mem_wdata;
                last_wstrb = mem_wstrb;
            end
            if (mem_bvalid && mem_bready) mem_bvalid <= 1'b0;
            if (got_aw && got_w && !mem_bvalid) begin
                if (aw_addr >= `UART_BASE && aw_addr < UART_END) begin // any UART register
                    uart_writes++;
                    last_waddr = aw_addr;
                    last_wdata = w_data;
                end else begin
                    mem_store[aw_addr] = w_data;
                end
                got_aw = 1'b0;
                got_w = 1'b0;
                mem_bvalid <= 1'b1;
            end
        end
    end

    task automatic add_row(input logic wr, input bus_addr_t a, input bus_data_t d,
                           input int full, input logic rx, input logic [7:0] rxb,
                           input bus_data_t exp, input int st, input int fi,
                           input int uw, input logic [7:0] txb);
        t_write[nrow] = wr;
        t_addr[nrow] = a;
        t_wdata[nrow] = d;
        t_full[nrow] = full;
        t_rx[nrow] = rx;
        t_rx_byte[nrow] = rxb;
        t_rdata[nrow] = exp;
        t_stat[nrow] = st;
        t_fifo[nrow] = fi;
        t_uwr[nrow] = uw;
        t_tx_byte[nrow] = txb;
        nrow++;
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic core_read(input bus_addr_t a, output bus_data_t d);
        @(posedge clk);
        core_arvalid <= 1'b1;
        core_araddr <= a;
        core_arlen <= '0;
        do @(negedge clk); while (!core_arready);
        @(posedge clk);
        core_arvalid <= 1'b0;
        do @(negedge clk); while (!core_rvalid);
        d = core_rdata;
        check("core_rlast", 64'(core_rlast), 64'h1);
        @(posedge clk);
    endtask

    task automatic core_write(input bus_addr_t a, input bus_data_t d);
        logic aw_ok, w_ok, aw_hs, w_hs;
        @(posedge clk);
        core_awvalid <= 1'b1;
        core_awaddr <= a;
        core_awlen <= '0;
        core_wvalid <= 1'b1;
        core_wdata <= d;
        core_wstrb <= 8'hff;
        core_wlast <= 1'b1;
        aw_ok = 1'b0;
        w_ok = 1'b0;
        while (!(aw_ok && w_ok)) begin
            @(negedge clk);
            aw_hs = core_awvalid & core_awready;
            w_hs = core_wvalid & core_wready;
            @(posedge clk);
            if (aw_hs) begin
                core_awvalid <= 1'b0;
                aw_ok = 1'b1;
            end
            if (w_hs) begin
                core_wvalid <= 1'b0;
                w_ok = 1'b1;
            end
        end
        do @(negedge clk); while (!core_bvalid);
        @(posedge clk);
    endtask

    task automatic run_row(input int i);
        int err0;
        bus_data_t got;
        @(negedge clk);
        err0 = errors;
        cur = i;
        stat_base = stat_reads;
        fifo_base = fifo_reads;
        uwr_base = uart_writes;
        if (t_write[i]) begin
            core_write(t_addr[i], t_wdata[i]);
        end else begin
            core_read(t_addr[i], got);
            check("core_rdata", got, t_rdata[i]);
        end
        do @(negedge clk); while (DUT.htif_active); // console job may still run
        check("uart status reads", 64'(stat_reads - stat_base), 64'(t_stat[i]));
        check("uart fifo reads", 64'(fifo_reads - fifo_base), 64'(t_fifo[i]));
        check("uart writes", 64'(uart_writes - uwr_base), 64'(t_uwr[i]));
        if (t_uwr[i] > 0) begin
            check("mem_awaddr", last_waddr, FIFO_ADDR);
            check("mem_wstrb", 64'(last_wstrb), 64'(`UART_TX_STRB));
            check("mem_wdata[39:32]", 64'(last_wdata[39:32]), 64'(t_tx_byte[i]));
        end
        $display("test %0d %s %h: %s", i, t_write[i] ? "write" : "read", t_addr[i],
                 (errors == err0) ? "ok" : "error");
    endtask

    initial begin
        void'($urandom(32'h0621_4312));
        rst = 1'b1;
        core_arvalid = 1'b0;
        core_awvalid = 1'b0;
        core_wvalid = 1'b0;
        core_rready = 1'b1;
        core_bready = 1'b1;
        core_araddr = '0;
        core_awaddr = '0;
        core_arlen = '0;
        core_awlen = '0;
        core_wdata = '0;
        core_wstrb = '0;
        core_wlast = 1'b0;
        cx = 8'($urandom);
        cy = 8'($urandom);
        rb = 8'($urandom);
        ord_data = {32'($urandom), 32'($urandom)};
        fv = {32'h0000_0201, 32'($urandom)}; // nonzero fromhost value
        add_row(1, ORD_ADDR, ord_data, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, ORD_ADDR, 0, 0, 0, 0, ord_data, 0, 0, 0, 0);
        add_row(1, `HTIF_TOHOST_ADDR, 64'h1, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, `HTIF_TOHOST_ADDR, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, `HTIF_TOHOST_ADDR, {8'd1, 8'd1, 40'd0, cx}, 0, 0, 0, 0, 1, 0, 1, cx);
        add_row(0, `HTIF_TOHOST_ADDR, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(1, `HTIF_TOHOST_ADDR, {8'd1, 8'd1, 40'd0, cy}, 3, 0, 0, 0, 4, 0, 1, cy);
        add_row(0, `HTIF_FROMHOST_ADDR, 0, 0, 1, rb, 0, 1, 1, 0, 0);
        add_row(0, `HTIF_FROMHOST_ADDR, 0, 0, 0, 0, {8'd1, 8'd0, 40'd0, rb}, 0, 0, 0, 0);
        add_row(1, `HTIF_FROMHOST_ADDR, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, `HTIF_FROMHOST_ADDR, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add_row(0, `HTIF_FROMHOST_ADDR, 0, 0, 0, 0, 0, 1, 0, 0, 0);
        add_row(1, `HTIF_FROMHOST_ADDR, fv, 0, 0, 0, 0, 0, 0, 0, 0);
        add_row(0, `HTIF_FROMHOST_ADDR, 0, 0, 0, 0, fv, 0, 0, 0, 0);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NROWS; i++) run_row(i);
        $display("tests %0d, checks %0d, errors %0d", NROWS, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+logic
logic/bus_pkg.sv
logic/htif_pkg.sv
logic/htif_slave.sv
logic/console_master.sv
logic/bus_steer.sv
logic/htif_uart_bridge.sv
test/bridge_tb.sv

/* Makefile */
SIM := obj_dir/Vbridge_tb

.PHONY: all run clean

all: run

$(SIM): list.f logic/htif_config.svh $(wildcard logic/*.sv) test/bridge_tb.sv
	verilator --binary --timing -f list.f --top-module bridge_tb -o Vbridge_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
